/* design/emu_ctrl_pkg.sv */
`default_nettype none

package emu_ctrl_pkg;

    // word address on the control bus.
    typedef logic [9:0] ctrl_addr_t;

    typedef struct packed {
        ctrl_addr_t  addr;
        logic [31:0] data;  // already strobe-masked.
    } ctrl_wr_t;

    // command fields, run in bit 0.
    typedef struct packed {
        logic [28:0] reserved;
        logic        clear;
        logic        step;
        logic        run;
    } ctrl_cmd_t;

    // one written word, seen as raw data or as a command.
    typedef union packed {
        logic [31:0] raw;
        ctrl_cmd_t   cmd;
    } ctrl_word_u;

    typedef struct packed {
        logic [29:0] zero;
        logic        halted;
        logic        running;
    } status_t;

    // register map, word addresses.
    localparam ctrl_addr_t REG_ID      = 10'd0;
    localparam ctrl_addr_t REG_SCRATCH = 10'd1;
    localparam ctrl_addr_t REG_CMD     = 10'd2;
    localparam ctrl_addr_t REG_STATUS  = 10'd3;
    localparam ctrl_addr_t REG_TARGET  = 10'd4;
    localparam ctrl_addr_t REG_COUNT   = 10'd5;

    localparam logic [31:0] ID_VALUE = 32'h454D_4331;

endpackage

`default_nettype wire

/* design/axil_ctrl_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module axil_ctrl_bridge (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     awvalid,
    output logic                     awready,
    input  logic [11:0]              awaddr,
    input  logic [2:0]               awprot,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [1:0]               bresp,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [11:0]              araddr,
    input  logic [2:0]               arprot,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,

    output logic                     wr_en,
    output emu_ctrl_pkg::ctrl_wr_t   wr,
    output logic                     rd_en,
    output emu_ctrl_pkg::ctrl_addr_t rd_addr,
    input  logic [31:0]              rd_data
);

    localparam logic [1:0] R_IDLE  = 2'd0;
    localparam logic [1:0] R_READ  = 2'd1;
    localparam logic [1:0] R_RESP  = 2'd2;

    localparam logic [1:0] W_IDLE  = 2'd0;
    localparam logic [1:0] W_DATA  = 2'd1;
    localparam logic [1:0] W_WRITE = 2'd2;
    localparam logic [1:0] W_RESP  = 2'd3;

    logic [1:0]  r_state;
    logic [1:0]  r_state_next;
    logic [1:0]  w_state;
    logic [1:0]  w_state_next;
    logic [31:0] rdata_q;
    logic [31:0] wstrb_mask;

    // read machine.
    always_ff @(posedge clk) begin
        if (rst) begin
            r_state <= R_IDLE;
        end else begin
            r_state <= r_state_next;
        end
    end

    always_comb begin
        case (r_state)
            R_IDLE:  r_state_next = arvalid ? R_READ : R_IDLE;
            R_READ:  r_state_next = R_RESP;
            R_RESP:  r_state_next = rready ? R_IDLE : R_RESP;
            default: r_state_next = R_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rd_addr <= araddr[11:2];
        end
        if (r_state == R_READ) begin
            rdata_q <= rd_data;  // held until rready.
        end
    end

    assign rd_en   = (r_state == R_READ);
    assign arready = (r_state == R_IDLE);
    assign rvalid  = (r_state == R_RESP);
    assign rdata   = rdata_q;
    assign rresp   = 2'b00;

    // write machine.
    always_ff @(posedge clk) begin
        if (rst) begin
            w_state <= W_IDLE;
        end else begin
            w_state <= w_state_next;
        end
    end

    always_comb begin
        case (w_state)
            W_IDLE:  w_state_next = awvalid ? W_DATA : W_IDLE;
            W_DATA:  w_state_next = wvalid ? W_WRITE : W_DATA;
            W_WRITE: w_state_next = W_RESP;
            W_RESP:  w_state_next = bready ? W_IDLE : W_RESP;
            default: w_state_next = W_IDLE;
        endcase
    end

    // disabled bytes go through as zero.
    assign wstrb_mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr.addr <= awaddr[11:2];
        end
        if (wvalid && wready) begin
            wr.data <= wdata & wstrb_mask;
        end
    end

    assign wr_en   = (w_state == W_WRITE);
    assign awready = (w_state == W_IDLE);
    assign wready  = (w_state == W_DATA);
    assign bvalid  = (w_state == W_RESP);
    assign bresp   = 2'b00;  // always OKAY.

endmodule

`default_nettype wire

/* design/ctrl_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_regfile #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     wr_en,
    input  emu_ctrl_pkg::ctrl_wr_t   wr,
    input  emu_ctrl_pkg::ctrl_addr_t rd_addr,
    output logic [31:0]              rd_data,

    output logic                     cmd_en,
    output emu_ctrl_pkg::ctrl_cmd_t  cmd,
    output logic [31:0]              target,
    input  logic [COUNT_WIDTH-1:0]   count,
    input  emu_ctrl_pkg::status_t    status
);

    import emu_ctrl_pkg::*;

    ctrl_word_u  word;
    logic [31:0] scratch;

    assign word = wr.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            scratch <= '0;
            target  <= '0;
        end else if (wr_en) begin
            case (wr.addr)
                REG_SCRATCH: scratch <= word.raw;
                REG_TARGET:  target  <= word.raw;
                default:     ;  // read-only or unmapped.
            endcase
        end
    end

    // command write becomes a one-cycle pulse.
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_en <= 1'b0;
        end else begin
            cmd_en <= wr_en && (wr.addr == REG_CMD);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && (wr.addr == REG_CMD)) begin
            cmd <= word.cmd;
        end
    end

    always_comb begin
        case (rd_addr)
            REG_ID:      rd_data = ID_VALUE;
            REG_SCRATCH: rd_data = scratch;
            REG_STATUS:  rd_data = status;
            REG_TARGET:  rd_data = target;
            REG_COUNT:   rd_data = 32'(count);  // zero-extended.
            default:     rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/step_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module step_counter #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_en,
    input  emu_ctrl_pkg::ctrl_cmd_t cmd,
    input  logic [31:0]             target,
    output logic [COUNT_WIDTH-1:0]  count,
    output emu_ctrl_pkg::status_t   status
);

    logic                   running;
    logic                   halted;
    logic [COUNT_WIDTH-1:0] tgt;
    logic [COUNT_WIDTH-1:0] count_inc;
    logic                   hit;

    assign tgt       = target[COUNT_WIDTH-1:0];
    assign count_inc = count + 1'b1;
    // target already reached, or reached on this edge.
    assign hit       = running && ((count == tgt) || (count_inc == tgt));

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
        end else begin
            if (running) begin
                if (count != tgt) begin
                    count <= count_inc;
                end
                if (hit) begin
                    running <= 1'b0;
                    halted  <= 1'b1;
                end
            end
            if (cmd_en) begin
                if (cmd.clear) begin
                    count  <= '0;
                    halted <= 1'b0;
                end else if (cmd.step && !running) begin
                    count <= count_inc;  // single step.
                end
                if (!cmd.run) begin
                    running <= 1'b0;
                end else if (cmd.clear || !(halted || hit)) begin
                    running <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        status         = '0;
        status.running = running;
        status.halted  = halted;
    end

endmodule

`default_nettype wire

/* design/emu_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module emu_ctrl_top #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        awvalid,
    output logic        awready,
    input  logic [11:0] awaddr,
    input  logic [2:0]  awprot,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [11:0] araddr,
    input  logic [2:0]  arprot,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    import emu_ctrl_pkg::*;

    logic                   wr_en;
    ctrl_wr_t               wr;
    logic                   rd_en;
    ctrl_addr_t             rd_addr;
    logic [31:0]            rd_data;
    logic                   cmd_en;
    ctrl_cmd_t              cmd;
    logic [31:0]            target;
    logic [COUNT_WIDTH-1:0] count;
    status_t                status;

    axil_ctrl_bridge i_bridge (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awprot  (awprot),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arprot  (arprot),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .wr_en   (wr_en),
        .wr      (wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ctrl_regfile #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_regfile (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .cmd_en  (cmd_en),
        .cmd     (cmd),
        .target  (target),
        .count   (count),
        .status  (status)
    );

    step_counter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_counter (
        .clk    (clk),
        .rst    (rst),
        .cmd_en (cmd_en),
        .cmd    (cmd),
        .target (target),
        .count  (count),
        .status (status)
    );

endmodule

`default_nettype wire

/* verification/tb_emu_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_emu_ctrl_top;

    import emu_ctrl_pkg::*;

    localparam int COUNT_WIDTH = 16;
    localparam int TIMEOUT     = 100;
    localparam logic [31:0] CMD_RUN   = 32'h0000_0001;
    localparam logic [31:0] CMD_STEP  = 32'h0000_0002;
    localparam logic [31:0] CMD_CLEAR = 32'h0000_0004;
    localparam logic [1:0]  OKAY      = 2'b00;

    logic        clk;
    logic        rst;
    logic        awvalid;
    logic        awready;
    logic [11:0] awaddr;
    logic [2:0]  awprot;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [11:0] araddr;
    logic [2:0]  arprot;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    logic [31:0] lfsr_state;

    emu_ctrl_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_emu_ctrl_top (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awprot  (awprot),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arprot  (arprot),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    always #10 clk = ~clk;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Errors found");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    // galois form, right shift, taps 32,22,2,1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w          = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // bytes with a cleared strobe bit come back as zero.
    function automatic logic [31:0] strobe_bytes(input logic [31:0] d, input logic [3:0] s);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                r[8*i +: 8] = d[8*i +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic [11:0] byte_addr(input ctrl_addr_t a);
        return {a, 2'b00};
    endfunction

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int bhold,
                             output logic [1:0] resp);
        int n;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        n = 0;
        while (!awready) begin
            @(negedge clk);
            n = n + 1;
            if (n > TIMEOUT) fail_timeout("awready");
        end
        @(negedge clk);  // address taken on the edge just passed.
        awvalid = 1'b0;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        n = 0;
        while (!wready) begin
            @(negedge clk);
            n = n + 1;
            if (n > TIMEOUT) fail_timeout("wready");
        end
        @(negedge clk);
        wvalid = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n = n + 1;
            if (n > TIMEOUT) fail_timeout("bvalid");
        end
        for (int i = 0; i < bhold; i++) begin
            check(32'(bvalid), 32'd1, "bvalid held under back-pressure");
            check(32'(awready), 32'd0, "awready while response pending");
            @(negedge clk);
        end
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, input int rhold,
                            input logic [31:0] hold_exp,
                            output logic [31:0] data, output logic [1:0] resp);
        int n;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n = n + 1;
            if (n > TIMEOUT) fail_timeout("arready");
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n = n + 1;
            if (n > TIMEOUT) fail_timeout("rvalid");
        end
        data = rdata;
        resp = rresp;
        for (int i = 0; i < rhold; i++) begin
            check(32'(rvalid), 32'd1, "rvalid held under back-pressure");
            check(rdata, hold_exp, "rdata held under back-pressure");
            @(negedge clk);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_reg(input ctrl_addr_t a, input logic [31:0] d, input logic [3:0] s);
        logic [1:0] resp;
        axi_write(byte_addr(a), d, s, 0, resp);
        check(32'(resp), 32'(OKAY), "bresp");
    endtask

    task automatic read_expect(input ctrl_addr_t a, input logic [31:0] exp, input string msg);
        logic [31:0] d;
        logic [1:0]  resp;
        axi_read(byte_addr(a), 0, exp, d, resp);
        check(d, exp, msg);
        check(32'(resp), 32'(OKAY), "rresp");
    endtask

    task automatic test_reset_state();
        check(32'(awready), 32'd1, "awready after reset");
        check(32'(arready), 32'd1, "arready after reset");
        check(32'(wready), 32'd0, "wready after reset");
        check(32'(bvalid), 32'd0, "bvalid after reset");
        check(32'(rvalid), 32'd0, "rvalid after reset");
        read_expect(REG_ID, ID_VALUE, "id register");
        read_expect(REG_STATUS, 32'd0, "status after reset");
    endtask

    task automatic test_scratch();
        logic [31:0] d;
        logic [3:0]  strbs [5];
        strbs = '{4'h1, 4'h6, 4'hA, 4'h0, 4'hC};
        for (int i = 0; i < 8; i++) begin
            random_word(d);
            write_reg(REG_SCRATCH, d, 4'hF);
            read_expect(REG_SCRATCH, d, "scratch full word");
        end
        foreach (strbs[i]) begin
            random_word(d);
            write_reg(REG_SCRATCH, d, strbs[i]);
            read_expect(REG_SCRATCH, strobe_bytes(d, strbs[i]), "scratch partial strobe");
        end
    endtask

    task automatic test_ignored();
        logic [31:0] d;
        random_word(d);
        write_reg(REG_ID, d, 4'hF);
        read_expect(REG_ID, ID_VALUE, "id after write");
        random_word(d);
        write_reg(REG_COUNT, d, 4'hF);
        read_expect(REG_COUNT, 32'd0, "count after write");
        random_word(d);
        write_reg(10'h040, d, 4'hF);
        read_expect(10'h040, 32'd0, "unmapped read");
        read_expect(REG_CMD, 32'd0, "command read");
    endtask

    task automatic test_single_step(input int n);
        write_reg(REG_CMD, CMD_CLEAR, 4'hF);
        for (int i = 0; i < n; i++) begin
            write_reg(REG_CMD, CMD_STEP, 4'hF);
        end
        read_expect(REG_COUNT, 32'(n), "count after steps");
        read_expect(REG_STATUS, 32'd0, "status after steps");
    endtask

    task automatic test_run_to_target(input int t);
        logic [31:0] d;
        logic [1:0]  resp;
        int          polls;
        write_reg(REG_CMD, CMD_CLEAR, 4'hF);
        write_reg(REG_TARGET, 32'(t), 4'hF);
        write_reg(REG_CMD, CMD_RUN, 4'hF);
        polls = 0;
        d     = '0;
        while (!d[1]) begin  // halted bit.
            axi_read(byte_addr(REG_STATUS), 0, '0, d, resp);
            polls = polls + 1;
            if (polls > TIMEOUT) fail_timeout("halted status");
        end
        read_expect(REG_COUNT, 32'(t), "count at target");
        read_expect(REG_STATUS, 32'h0000_0002, "status halted, not running");
        write_reg(REG_CMD, CMD_CLEAR, 4'hF);
        read_expect(REG_COUNT, 32'd0, "count after clear");
        read_expect(REG_STATUS, 32'd0, "status after clear");
    endtask

    task automatic test_back_pressure();
        logic [31:0] d;
        logic [31:0] got;
        logic [1:0]  resp;
        random_word(d);
        axi_write(byte_addr(REG_SCRATCH), d, 4'hF, 4, resp);
        check(32'(resp), 32'(OKAY), "bresp with bready held");
        axi_read(byte_addr(REG_SCRATCH), 5, d, got, resp);
        check(got, d, "rdata with rready held");
        check(32'(resp), 32'(OKAY), "rresp with rready held");
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        awvalid    = 1'b0;
        awaddr     = '0;
        awprot     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        arprot     = '0;
        rready     = 1'b0;
        lfsr_state = 32'd2034;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_scratch();
        test_ignored();
        test_single_step(5);
        test_run_to_target(37);
        test_back_pressure();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/emu_ctrl_pkg.sv
design/axil_ctrl_bridge.sv
design/ctrl_regfile.sv
design/step_counter.sv
design/emu_ctrl_top.sv
verification/tb_emu_ctrl_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_emu_ctrl_top \
    -f src.f \
    -o sim_emu_ctrl

./obj_dir/sim_emu_ctrl
